// ==== wd_pkg.sv ====
package wd_pkg;

   // ----------------------------------------
   // Channel widths
   // ----------------------------------------
   localparam int ID_WIDTH    = 4;
   localparam int DATA_WIDTH  = 64;
   localparam int STRB_WIDTH  = DATA_WIDTH / 8;
   localparam int ADDR_WIDTH  = 32;

   // Master slots, also the grant code width
   localparam int MAX_MASTERS = 4;

   // ----------------------------------------
   // Beat and address types
   // ----------------------------------------
   typedef logic [ID_WIDTH-1:0]   wd_id_t;
   typedef logic [DATA_WIDTH-1:0] wd_data_t;
   typedef logic [STRB_WIDTH-1:0] wd_strb_t;
   typedef logic [ADDR_WIDTH-1:0] wd_addr_t;

   // Bits 3..0 region, bit 4 accepts every region
   typedef logic [4:0]            slave_num_t;

   // ----------------------------------------
   // Grant code from the arbiter
   // ----------------------------------------
   // One-hot per master, anything else means no grant
   typedef enum logic [MAX_MASTERS-1:0] {
      GNT_NONE = 4'b0000,
      GNT_M0   = 4'b0001,
      GNT_M1   = 4'b0010,
      GNT_M2   = 4'b0100,
      GNT_M3   = 4'b1000
   } gnt_code_t;

endpackage

// ==== wd_forward_mux.sv ====
`timescale 1ns/10ps

module wd_forward_mux #(
   parameter int NUM_MASTERS = 4
) (
   input  logic               ACLK,
   input  logic               aresetn,

   // Grant from the arbiter
   input  wd_pkg::gnt_code_t  mst_gnt_num,

   // Master write data beats
   input  wd_pkg::wd_id_t     wid_m    [wd_pkg::MAX_MASTERS],
   input  wd_pkg::wd_data_t   wdata_m  [wd_pkg::MAX_MASTERS],
   input  wd_pkg::wd_strb_t   wstrb_m  [wd_pkg::MAX_MASTERS],
   input  logic               wlast_m  [wd_pkg::MAX_MASTERS],
   input  logic               wvalid_m [wd_pkg::MAX_MASTERS],

   // Slave selection
   input  wd_pkg::slave_num_t slave_number,
   input  wd_pkg::wd_addr_t   awaddr,

   // Slave side beat
   output wd_pkg::wd_id_t     wid_s,
   output wd_pkg::wd_data_t   wdata_s,
   output wd_pkg::wd_strb_t   wstrb_s,
   output logic               wlast_s,
   output logic               wvalid_s
);
   import wd_pkg::*;

   localparam int IDX_W    = $clog2(MAX_MASTERS);
   localparam int REGION_W = 4;

   logic [IDX_W-1:0] grant_idx;
   logic             grant_hit;

   wd_id_t           beat_id;
   wd_data_t         beat_data;
   wd_strb_t         beat_strb;
   logic             beat_last;
   logic             beat_valid;

   logic             slave_sel;

   // ----------------------------------------
   // Grant decode
   // ----------------------------------------
   // Illegal codes fall to default and forward nothing
   always_comb begin
      grant_idx = '0;
      grant_hit = 1'b0;
      case (mst_gnt_num)
         GNT_M0: begin
            grant_idx = IDX_W'(0);
            grant_hit = 1'b1;
         end
         GNT_M1: begin
            grant_idx = IDX_W'(1);
            grant_hit = 1'b1;
         end
         GNT_M2: begin
            grant_idx = IDX_W'(2);
            grant_hit = 1'b1;
         end
         GNT_M3: begin
            grant_idx = IDX_W'(3);
            grant_hit = 1'b1;
         end
         default: begin
            grant_idx = '0;
            grant_hit = 1'b0;
         end
      endcase
   end

   // ----------------------------------------
   // Beat mux
   // ----------------------------------------
   // Slots beyond NUM_MASTERS are not populated
   always_comb begin
      beat_id    = '0;
      beat_data  = '0;
      beat_strb  = '0;
      beat_last  = 1'b0;
      beat_valid = 1'b0;
      if (grant_hit && (int'(grant_idx) < NUM_MASTERS)) begin
         beat_id    = wid_m[grant_idx];
         beat_data  = wdata_m[grant_idx];
         beat_strb  = wstrb_m[grant_idx];
         beat_last  = wlast_m[grant_idx];
         beat_valid = wvalid_m[grant_idx];
      end
   end

   // ----------------------------------------
   // Slave select
   // ----------------------------------------
   // Region match on the top address nibble, or accept-all flag
   assign slave_sel = slave_number[4] ||
      (slave_number[REGION_W-1:0] == awaddr[ADDR_WIDTH-1 -: REGION_W]);

   // ----------------------------------------
   // Slave side register
   // ----------------------------------------
   always_ff @(posedge ACLK or negedge aresetn) begin
      if (!aresetn) begin
         wid_s    <= '0;
         wdata_s  <= '0;
         wstrb_s  <= '0;
         wlast_s  <= 1'b0;
         wvalid_s <= 1'b0;
      end else if (slave_sel) begin
         wid_s    <= beat_id;
         wdata_s  <= beat_data;
         wstrb_s  <= beat_strb;
         wlast_s  <= beat_last;
         wvalid_s <= beat_valid;
      end else begin
         // Not our region, slave sees an idle bus
         wid_s    <= '0;
         wdata_s  <= '0;
         wstrb_s  <= '0;
         wlast_s  <= 1'b0;
         wvalid_s <= 1'b0;
      end
   end

endmodule

// ==== wd_ready_return.sv ====
`timescale 1ns/10ps

module wd_ready_return #(
   parameter int NUM_MASTERS = 4
) (
   input  logic              ACLK,
   input  logic              aresetn,

   // Grant from the arbiter, same cycle as the forward mux
   input  wd_pkg::gnt_code_t mst_gnt_num,

   // Ready from the slave
   input  logic              wready_s,

   // Ready back to each master
   output logic              wready_m [wd_pkg::MAX_MASTERS]
);
   import wd_pkg::*;

   gnt_code_t              gnt_q;
   logic [MAX_MASTERS-1:0] ready_dmx;

   // ----------------------------------------
   // Delayed grant
   // ----------------------------------------
   // Lines up with the beat sitting in the forward register
   always_ff @(posedge ACLK or negedge aresetn) begin
      if (!aresetn) begin
         gnt_q <= GNT_NONE;
      end else begin
         gnt_q <= mst_gnt_num;
      end
   end

   // ----------------------------------------
   // Ready demux
   // ----------------------------------------
   always_comb begin
      ready_dmx = '0;
      case (gnt_q)
         GNT_M0: begin
            ready_dmx[0] = wready_s;
         end
         GNT_M1: begin
            ready_dmx[1] = wready_s;
         end
         GNT_M2: begin
            ready_dmx[2] = wready_s;
         end
         GNT_M3: begin
            ready_dmx[3] = wready_s;
         end
         default: begin
            ready_dmx = '0;
         end
      endcase

      // Unused slots never see ready
      for (int k = 0; k < MAX_MASTERS; k++) begin
         if (k >= NUM_MASTERS) begin
            ready_dmx[k] = 1'b0;
         end
      end
   end

   // ----------------------------------------
   // Ready output register
   // ----------------------------------------
   // Breaks the slave ready to master path for timing
   always_ff @(posedge ACLK or negedge aresetn) begin
      if (!aresetn) begin
         for (int k = 0; k < MAX_MASTERS; k++) begin
            wready_m[k] <= 1'b0;
         end
      end else begin
         for (int k = 0; k < MAX_MASTERS; k++) begin
            wready_m[k] <= ready_dmx[k];
         end
      end
   end

endmodule

// ==== wd_channel.sv ====
`timescale 1ns/10ps

module wd_channel #(
   parameter int NUM_MASTERS = 4
) (
   // Clock and reset
   input  logic               ACLK,
   input  logic               aresetn,

   // Grant from the arbiter
   input  wd_pkg::gnt_code_t  mst_gnt_num,

   // ----------------------------------------
   // Master ports
   // ----------------------------------------
   input  wd_pkg::wd_id_t     wid_m    [wd_pkg::MAX_MASTERS],
   input  wd_pkg::wd_data_t   wdata_m  [wd_pkg::MAX_MASTERS],
   input  wd_pkg::wd_strb_t   wstrb_m  [wd_pkg::MAX_MASTERS],
   input  logic               wlast_m  [wd_pkg::MAX_MASTERS],
   input  logic               wvalid_m [wd_pkg::MAX_MASTERS],
   output logic               wready_m [wd_pkg::MAX_MASTERS],

   // ----------------------------------------
   // Slave port
   // ----------------------------------------
   output wd_pkg::wd_id_t     wid_s,
   output wd_pkg::wd_data_t   wdata_s,
   output wd_pkg::wd_strb_t   wstrb_s,
   output logic               wlast_s,
   output logic               wvalid_s,
   input  logic               wready_s,

   // Slave identity and current write address
   input  wd_pkg::slave_num_t slave_number,
   input  wd_pkg::wd_addr_t   awaddr
);

   // Forward path, one register stage to the slave
   wd_forward_mux #(
      .NUM_MASTERS  (NUM_MASTERS)
   ) u_forward_mux (
      .ACLK         (ACLK),
      .aresetn      (aresetn),
      .mst_gnt_num  (mst_gnt_num),
      .wid_m        (wid_m),
      .wdata_m      (wdata_m),
      .wstrb_m      (wstrb_m),
      .wlast_m      (wlast_m),
      .wvalid_m     (wvalid_m),
      .slave_number (slave_number),
      .awaddr       (awaddr),
      .wid_s        (wid_s),
      .wdata_s      (wdata_s),
      .wstrb_s      (wstrb_s),
      .wlast_s      (wlast_s),
      .wvalid_s     (wvalid_s)
   );

   // Ready path, steered by the delayed grant
   wd_ready_return #(
      .NUM_MASTERS  (NUM_MASTERS)
   ) u_ready_return (
      .ACLK         (ACLK),
      .aresetn      (aresetn),
      .mst_gnt_num  (mst_gnt_num),
      .wready_s     (wready_s),
      .wready_m     (wready_m)
   );

endmodule

// ==== wd_checker.sv ====
`timescale 1ns/10ps

module wd_checker #(
   parameter int NAME_W = 8 * 24
) (
   input  logic                          ACLK,
   input  logic                          aresetn,

   // DUT slave side and ready return
   input  wd_pkg::wd_id_t                wid_s,
   input  wd_pkg::wd_data_t              wdata_s,
   input  wd_pkg::wd_strb_t              wstrb_s,
   input  logic                          wlast_s,
   input  logic                          wvalid_s,
   input  logic                          wready_m [wd_pkg::MAX_MASTERS],

   // Expected values of the line being driven
   input  logic                          check_en,
   input  logic [NAME_W-1:0]             test_name,
   input  wd_pkg::wd_id_t                exp_wid,
   input  wd_pkg::wd_data_t              exp_wdata,
   input  wd_pkg::wd_strb_t              exp_wstrb,
   input  logic                          exp_wlast,
   input  logic                          exp_wvalid,
   input  logic [wd_pkg::MAX_MASTERS-1:0] exp_wready,

   output int                            error_count,
   output int                            check_count
);
   import wd_pkg::*;

   int                     errors = 0;
   int                     checks = 0;

   logic                   rst_q = 1'b1;
   logic                   chk_q = 1'b0;
   logic [NAME_W-1:0]      name_q;
   wd_id_t                 wid_q;
   wd_data_t               wdata_q;
   wd_strb_t               wstrb_q;
   logic                   wlast_q;
   logic                   wvalid_q;
   logic [MAX_MASTERS-1:0] wready_q;
   logic [MAX_MASTERS-1:0] ready_act;

   assign error_count = errors;
   assign check_count = checks;

   always_comb begin
      for (int k = 0; k < MAX_MASTERS; k++) begin
         ready_act[k] = wready_m[k];
      end
   end

   // ----------------------------------------
   // Capture expectations with the DUT inputs
   // ----------------------------------------
   always @(posedge ACLK) begin
      rst_q    <= !aresetn;
      chk_q    <= check_en;
      name_q   <= test_name;
      wid_q    <= exp_wid;
      wdata_q  <= exp_wdata;
      wstrb_q  <= exp_wstrb;
      wlast_q  <= exp_wlast;
      wvalid_q <= exp_wvalid;
      wready_q <= exp_wready;
   end

   task automatic compare_value(input logic [NAME_W-1:0] tname, input string field,
                                input logic [63:0] exp, input logic [63:0] act);
      if (act !== exp) begin
         errors++;
         $display("ERR %0s %0s expected %0h actual %0h", tname, field, exp, act);
      end
   endtask

   // ----------------------------------------
   // Compare mid cycle, outputs are settled
   // ----------------------------------------
   always @(negedge ACLK) begin
      if (rst_q) begin
         // Reset and the first cycle after release
         checks++;
         compare_value(NAME_W'("reset"), "wid_s", 64'(0), 64'(wid_s));
         compare_value(NAME_W'("reset"), "wdata_s", 64'(0), 64'(wdata_s));
         compare_value(NAME_W'("reset"), "wstrb_s", 64'(0), 64'(wstrb_s));
         compare_value(NAME_W'("reset"), "wlast_s", 64'(0), 64'(wlast_s));
         compare_value(NAME_W'("reset"), "wvalid_s", 64'(0), 64'(wvalid_s));
         compare_value(NAME_W'("reset"), "wready_m", 64'(0), 64'(ready_act));
      end else if (chk_q) begin
         checks++;
         compare_value(name_q, "wid_s", 64'(wid_q), 64'(wid_s));
         compare_value(name_q, "wdata_s", 64'(wdata_q), 64'(wdata_s));
         compare_value(name_q, "wstrb_s", 64'(wstrb_q), 64'(wstrb_s));
         compare_value(name_q, "wlast_s", 64'(wlast_q), 64'(wlast_s));
         compare_value(name_q, "wvalid_s", 64'(wvalid_q), 64'(wvalid_s));
         compare_value(name_q, "wready_m", 64'(wready_q), 64'(ready_act));
      end
   end

endmodule

// ==== wd_channel_sva.sv ====
`timescale 1ns/10ps

module wd_channel_sva #(
   parameter int NUM_MASTERS = 4
) (
   input  logic               ACLK,
   input  logic               aresetn,
   input  wd_pkg::wd_id_t     wid_s,
   input  wd_pkg::wd_data_t   wdata_s,
   input  wd_pkg::wd_strb_t   wstrb_s,
   input  logic               wlast_s,
   input  logic               wvalid_s,
   input  logic               wready_m [wd_pkg::MAX_MASTERS]
);
   import wd_pkg::*;

   // Slots the arbiter can actually grant
   localparam logic [MAX_MASTERS-1:0] USED_MASK = MAX_MASTERS'((1 << NUM_MASTERS) - 1);

   logic [MAX_MASTERS-1:0] ready_vec;

   always_comb begin
      for (int k = 0; k < MAX_MASTERS; k++) begin
         ready_vec[k] = wready_m[k];
      end
   end

   a_reset_idle: assert property (@(posedge ACLK)
      !aresetn |-> (wid_s == '0 && wdata_s == '0 && wstrb_s == '0 &&
                    !wlast_s && !wvalid_s && ready_vec == '0))
      else $error("Outputs not idle while reset is held");

   a_ready_onehot: assert property (@(posedge ACLK) disable iff (!aresetn)
      $onehot0(ready_vec))
      else $error("More than one wready_m high at once");

   a_ready_unused: assert property (@(posedge ACLK) disable iff (!aresetn)
      (ready_vec & ~USED_MASK) == '0)
      else $error("wready_m high for a master that is not populated");

endmodule

bind wd_channel wd_channel_sva #(
   .NUM_MASTERS (NUM_MASTERS)
) u_sva (
   .ACLK        (ACLK),
   .aresetn     (aresetn),
   .wid_s       (wid_s),
   .wdata_s     (wdata_s),
   .wstrb_s     (wstrb_s),
   .wlast_s     (wlast_s),
   .wvalid_s    (wvalid_s),
   .wready_m    (wready_m)
);

// ==== tb_wd_channel.sv ====
`timescale 1ns/10ps

module tb_wd_channel;
   import wd_pkg::*;

   localparam int NUM_MASTERS = 4;
   localparam int MAX_LINES   = 64;
   localparam int NAME_W      = 8 * 24;

   // ----------------------------------------
   // DUT signals
   // ----------------------------------------
   logic                   ACLK;
   logic                   aresetn;
   gnt_code_t              mst_gnt_num;
   wd_id_t                 wid_m    [MAX_MASTERS];
   wd_data_t               wdata_m  [MAX_MASTERS];
   wd_strb_t               wstrb_m  [MAX_MASTERS];
   logic                   wlast_m  [MAX_MASTERS];
   logic                   wvalid_m [MAX_MASTERS];
   logic                   wready_m [MAX_MASTERS];
   wd_id_t                 wid_s;
   wd_data_t               wdata_s;
   wd_strb_t               wstrb_s;
   logic                   wlast_s;
   logic                   wvalid_s;
   logic                   wready_s;
   slave_num_t             slave_number;
   wd_addr_t               awaddr;

   // Expected values handed to the checker
   logic                   check_en;
   logic [NAME_W-1:0]      test_name;
   wd_id_t                 exp_wid;
   wd_data_t               exp_wdata;
   wd_strb_t               exp_wstrb;
   logic                   exp_wlast;
   logic                   exp_wvalid;
   logic [MAX_MASTERS-1:0] exp_wready;
   int                     error_count;
   int                     check_count;

   // Pattern table, one entry per cycle
   logic [NAME_W-1:0]      pat_name   [MAX_LINES];
   logic [3:0]             pat_gnt    [MAX_LINES];
   slave_num_t             pat_slave  [MAX_LINES];
   logic [3:0]             pat_nibble [MAX_LINES];
   wd_data_t               pat_seed   [MAX_LINES];
   logic                   pat_ready  [MAX_LINES];
   wd_id_t                 pat_wid    [MAX_LINES];
   wd_data_t               pat_wdata  [MAX_LINES];
   wd_strb_t               pat_wstrb  [MAX_LINES];
   logic                   pat_wlast  [MAX_LINES];
   logic                   pat_wvalid [MAX_LINES];
   logic [MAX_MASTERS-1:0] pat_wready [MAX_LINES];
   int                     num_lines;
   logic                   loaded = 1'b0;

   wd_channel #(
      .NUM_MASTERS  (NUM_MASTERS)
   ) u_dut (
      .ACLK         (ACLK),
      .aresetn      (aresetn),
      .mst_gnt_num  (mst_gnt_num),
      .wid_m        (wid_m),
      .wdata_m      (wdata_m),
      .wstrb_m      (wstrb_m),
      .wlast_m      (wlast_m),
      .wvalid_m     (wvalid_m),
      .wready_m     (wready_m),
      .wid_s        (wid_s),
      .wdata_s      (wdata_s),
      .wstrb_s      (wstrb_s),
      .wlast_s      (wlast_s),
      .wvalid_s     (wvalid_s),
      .wready_s     (wready_s),
      .slave_number (slave_number),
      .awaddr       (awaddr)
   );

   wd_checker #(
      .NAME_W       (NAME_W)
   ) u_checker (
      .ACLK         (ACLK),
      .aresetn      (aresetn),
      .wid_s        (wid_s),
      .wdata_s      (wdata_s),
      .wstrb_s      (wstrb_s),
      .wlast_s      (wlast_s),
      .wvalid_s     (wvalid_s),
      .wready_m     (wready_m),
      .check_en     (check_en),
      .test_name    (test_name),
      .exp_wid      (exp_wid),
      .exp_wdata    (exp_wdata),
      .exp_wstrb    (exp_wstrb),
      .exp_wlast    (exp_wlast),
      .exp_wvalid   (exp_wvalid),
      .exp_wready   (exp_wready),
      .error_count  (error_count),
      .check_count  (check_count)
   );

   initial ACLK = 1'b0;
   always #5 ACLK = ~ACLK;

   task automatic clear_inputs();
      for (int k = 0; k < MAX_MASTERS; k++) begin
         wid_m[k]    = '0;
         wdata_m[k]  = '0;
         wstrb_m[k]  = '0;
         wlast_m[k]  = 1'b0;
         wvalid_m[k] = 1'b0;
      end
      mst_gnt_num  = GNT_NONE;
      wready_s     = 1'b0;
      slave_number = '0;
      awaddr       = '0;
      check_en     = 1'b0;
      test_name    = '0;
      exp_wid      = '0;
      exp_wdata    = '0;
      exp_wstrb    = '0;
      exp_wlast    = 1'b0;
      exp_wvalid   = 1'b0;
      exp_wready   = '0;
   endtask

   // ----------------------------------------
   // Pattern file reader
   // ----------------------------------------
   task automatic load_patterns(output bit ok);
      int                     fd;
      int                     code;
      bit                     done;
      bit                     bad;
      logic [NAME_W-1:0]      tok;
      logic [8*200-1:0]       skip_buf;
      logic [3:0]             gnt;
      slave_num_t             sn;
      logic [3:0]             nib;
      wd_data_t               seed;
      logic                   rdy;
      wd_id_t                 wid;
      wd_data_t               wdata;
      wd_strb_t               wstrb;
      logic                   wlast;
      logic                   wvalid;
      logic [MAX_MASTERS-1:0] wready;
      num_lines = 0;
      done = 1'b0;
      bad  = 1'b0;
      fd = $fopen("wd_patterns.txt", "r");
      if (fd == 0) begin
         done = 1'b1;
         bad  = 1'b1;
      end
      while (!done) begin
         tok  = '0;
         code = $fscanf(fd, "%s", tok);
         if (code != 1 || num_lines >= MAX_LINES) begin
            done = 1'b1;
         end else if (tok == NAME_W'("#")) begin
            // Comment line, drop the rest of it
            code = $fgets(skip_buf, fd);
         end else begin
            code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h", gnt, sn, nib, seed,
                           rdy, wid, wdata, wstrb, wlast, wvalid, wready);
            if (code != 11) begin
               $display("Pattern line for %0s is incomplete", tok);
               bad  = 1'b1;
               done = 1'b1;
            end else begin
               pat_name[num_lines]   = tok;
               pat_gnt[num_lines]    = gnt;
               pat_slave[num_lines]  = sn;
               pat_nibble[num_lines] = nib;
               pat_seed[num_lines]   = seed;
               // Filler lines expect an idle slave, so any data will do
               if (tok == NAME_W'("filler")) begin
                  pat_seed[num_lines] = {$urandom, $urandom};
               end
               pat_ready[num_lines]  = rdy;
               pat_wid[num_lines]    = wid;
               pat_wdata[num_lines]  = wdata;
               pat_wstrb[num_lines]  = wstrb;
               pat_wlast[num_lines]  = wlast;
               pat_wvalid[num_lines] = wvalid;
               pat_wready[num_lines] = wready;
               num_lines++;
            end
         end
      end
      if (fd != 0) begin
         $fclose(fd);
      end
      ok = !bad && (num_lines > 0);
   endtask

   // Master k carries seed + k, ID k, full strobes, last on odd k
   task automatic drive_line(input int i);
      for (int k = 0; k < MAX_MASTERS; k++) begin
         wid_m[k]    = ID_WIDTH'(k);
         wdata_m[k]  = pat_seed[i] + DATA_WIDTH'(k);
         wstrb_m[k]  = '1;
         wlast_m[k]  = (k % 2) == 1;
         wvalid_m[k] = 1'b1;
      end
      mst_gnt_num  = gnt_code_t'(pat_gnt[i]);
      slave_number = pat_slave[i];
      awaddr       = {pat_nibble[i], 28'(i * 16)};
      wready_s     = pat_ready[i];
      check_en     = 1'b1;
      test_name    = pat_name[i];
      exp_wid      = pat_wid[i];
      exp_wdata    = pat_wdata[i];
      exp_wstrb    = pat_wstrb[i];
      exp_wlast    = pat_wlast[i];
      exp_wvalid   = pat_wvalid[i];
      exp_wready   = pat_wready[i];
   endtask

   // ----------------------------------------
   // Main sequence
   // ----------------------------------------
   initial begin
      bit ok;
      clear_inputs();
      aresetn = 1'b1;
      void'($urandom(32'h5f6f));
      load_patterns(ok);
      if (!ok) begin
         $display("Could not read the pattern lines from wd_patterns.txt");
         $display("TEST FAILED");
         $finish;
      end else begin
         loaded = 1'b1;
         #1;
         aresetn = 1'b0;
         repeat (4) @(posedge ACLK);
         #1;
         aresetn = 1'b1;
         for (int i = 0; i < num_lines; i++) begin
            drive_line(i);
            @(posedge ACLK);
            #1;
         end
         check_en = 1'b0;
         @(posedge ACLK);
         #1;
         $display("Cycles checked: %0d, errors: %0d", check_count, error_count);
         if (error_count == 0) begin
            $display("TEST PASSED");
         end else begin
            $display("TEST FAILED");
         end
         $finish;
      end
   end

   // Watchdog, two cycles per pattern line plus margin
   initial begin
      int limit_ns;
      wait (loaded);
      limit_ns = num_lines * 10 * 2 + 200;
      #(limit_ns);
      $display("Timeout: the run did not finish within %0d ns", limit_ns);
      $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== wd_patterns.txt ====
# name grant slave nibble seed ready_s | wid wdata wstrb wlast wvalid wready_m
# hex fields, one cycle per line; filler lines get a random data seed
idle        0 03 3 0000000000000000 0 0 0000000000000000 00 0 0 0
mux_m0      1 03 3 0000000000001000 1 0 0000000000001000 ff 0 1 0
mux_m1      2 03 3 0000000000001000 1 1 0000000000001001 ff 1 1 1
mux_m2      4 03 3 00000000a5a50000 1 2 00000000a5a50002 ff 0 1 2
mux_m3      8 03 3 ffffffffffffff00 1 3 ffffffffffffff03 ff 1 1 4
ready_low   1 03 3 0000000000002000 0 0 0000000000002000 ff 0 1 0
ready_m0    2 03 3 0000000000002000 1 1 0000000000002001 ff 1 1 1
sel_miss    4 03 7 0000000000003000 1 0 0000000000000000 00 0 0 2
sel_all     4 13 7 0000000000003000 1 2 0000000000003002 ff 0 1 4
sel_region  8 0a a 0000000000003000 1 3 0000000000003003 ff 1 1 4
no_grant    0 0a a 0000000000004000 1 0 0000000000000000 00 0 0 8
bad_grant   3 0a a 0000000000004000 1 0 0000000000000000 00 0 0 0
after_bad   1 0a a 0000000000004000 1 0 0000000000004000 ff 0 1 0
filler      0 05 5 0000000000000000 1 0 0000000000000000 00 0 0 1
filler      2 05 9 0000000000000000 0 0 0000000000000000 00 0 0 0
filler      0 00 0 0000000000000000 1 0 0000000000000000 00 0 0 2
sel_all_m1  2 1f 0 0000000000005000 1 1 0000000000005001 ff 1 1 0
drain       0 00 0 0000000000000000 1 0 0000000000000000 00 0 0 2
drain_end   0 00 0 0000000000000000 0 0 0000000000000000 00 0 0 0

// ==== all.f ====
wd_pkg.sv
wd_forward_mux.sv
wd_ready_return.sv
wd_channel.sv
wd_checker.sv
wd_channel_sva.sv
tb_wd_channel.sv

// ==== Makefile ====
TOP := tb_wd_channel

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

obj_dir/V$(TOP): all.f $(wildcard *.sv)
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o V$(TOP)

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
